// File: hdl/ccm_cfg_pkg.sv
/*
 * CCM configuration package: APB address layout, register map and default sizes
 */
`default_nettype none

package ccm_cfg_pkg;

   // ******************************
   // Address layout
   // ******************************
   localparam int ADDR_W   = 16;    // APB address width
   localparam int OFFSET_W = 13;    // Word offset field of the memory view
   localparam int CNT_W    = 16;    // Error counter width

   // Memory view, region bit clear
   typedef struct packed {
      logic                region;
      logic [OFFSET_W-1:0] word_offset;
      logic [1:0]          byte_sel;
   } ccm_mem_view_t;

   // Register view, region bit set
   typedef struct packed {
      logic        region;
      logic [10:0] unused;
      logic [1:0]  reg_sel;
      logic [1:0]  byte_sel;
   } ccm_csr_view_t;

   // Same APB address, read either as a memory offset or a register select
   typedef union packed {
      ccm_mem_view_t mem;
      ccm_csr_view_t csr;
   } ccm_addr_u;

   // ******************************
   // Register selects
   // ******************************
   localparam logic [1:0] REG_CTRL    = 2'd0;  // Bit 0 is ecc_disable
   localparam logic [1:0] REG_INJECT  = 2'd1;  // One-shot data flip mask
   localparam logic [1:0] REG_SEC_CNT = 2'd2;  // Corrected errors
   localparam logic [1:0] REG_DED_CNT = 2'd3;  // Uncorrectable errors

   // Top level defaults
   localparam int DEF_NUM_BANKS  = 4;
   localparam int DEF_BANK_DEPTH = 256;

endpackage

`default_nettype wire

// File: hdl/ccm_ecc_pkg.sv
/*
 * SECDED code for 32-bit words: Hamming(38,32) plus an overall parity bit
 */
`default_nettype none

package ccm_ecc_pkg;

   // Stored word, check bits above the data
   typedef struct packed {
      logic [6:0]  ecc;     // [5:0] Hamming checks, [6] overall parity
      logic [31:0] data;
   } ccm_code_t;

   typedef struct packed {
      logic [31:0] data;
      logic        sec;
      logic        ded;
   } ecc_result_t;

   // Data bits sit at the Hamming positions that are not powers of two
   function automatic ccm_code_t ecc_encode(input logic [31:0] data);
      logic [38:1] hv;
      logic [5:0]  chk;
      ccm_code_t   cw;
      int          di;
      hv  = '0;
      chk = '0;
      di  = 0;
      for (int p = 1; p <= 38; p++) begin
         if ((p & (p - 1)) != 0) begin
            hv[p] = data[di];
            di++;
         end
      end
      for (int k = 0; k < 6; k++) begin
         for (int p = 1; p <= 38; p++) begin
            if (((p >> k) & 1) != 0) chk[k] ^= hv[p];
         end
      end
      cw.data = data;
      cw.ecc  = {(^data) ^ (^chk), chk};
      return cw;
   endfunction

   function automatic ecc_result_t ecc_decode(input ccm_code_t cw);
      logic [38:1] hv;
      logic [5:0]  syn;
      logic        ovr;
      ecc_result_t res;
      int          di;
      int          ci;
      di  = 0;
      ci  = 0;
      syn = '0;
      for (int p = 1; p <= 38; p++) begin
         if ((p & (p - 1)) == 0) begin
            hv[p] = cw.ecc[ci];
            ci++;
         end else begin
            hv[p] = cw.data[di];
            di++;
         end
      end
      for (int k = 0; k < 6; k++) begin
         for (int p = 1; p <= 38; p++) begin
            if (((p >> k) & 1) != 0) syn[k] ^= hv[p];
         end
      end
      ovr     = (^cw.data) ^ (^cw.ecc);
      res.sec = 1'b0;
      res.ded = 1'b0;
      if (ovr) begin
         if (syn <= 6'd38) begin
            res.sec = 1'b1;                       // Zero syndrome: parity bit itself
            if (syn != '0) hv[syn] = ~hv[syn];    // Check bit hits leave data alone
         end else begin
            res.ded = 1'b1;                       // Points past the word
         end
      end else if (syn != '0) begin
         res.ded = 1'b1;
      end
      di = 0;
      for (int p = 1; p <= 38; p++) begin
         if ((p & (p - 1)) != 0) begin
            res.data[di] = hv[p];
            di++;
         end
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// File: hdl/ccm_if.sv
/*
 * CCM interfaces: request channel from the APB front end to the bank
 * controller, and the per-bank SRAM channel
 */
`timescale 1ns/100ps
`default_nettype none

// BANK_AW here is the word address width across all banks
interface ccm_req_if #(
   parameter int BANK_AW = 10
);
   logic               req;          // One-cycle pulse
   logic               we;
   logic [BANK_AW-1:0] word_offset;
   logic [31:0]        wdata;
   logic [31:0]        flip_mask;
   logic               ecc_disable;
   logic               rvalid;       // One cycle after a read req
   logic [31:0]        rdata;
   logic               sec;
   logic               ded;

   modport front (output req, we, word_offset, wdata, flip_mask, ecc_disable,
                  input  rvalid, rdata, sec, ded);
   modport ctrl  (input  req, we, word_offset, wdata, flip_mask, ecc_disable,
                  output rvalid, rdata, sec, ded);
endinterface

interface ccm_sram_if
   import ccm_ecc_pkg::*;
#(
   parameter int NUM_BANKS = 4,
   parameter int BANK_AW   = 8
);
   logic [NUM_BANKS-1:0] en;
   logic [NUM_BANKS-1:0] we;
   logic [BANK_AW-1:0]   addr  [NUM_BANKS];
   ccm_code_t            wdata [NUM_BANKS];
   ccm_code_t            rdata [NUM_BANKS];   // One element per bank

   modport ctrl (output en, we, addr, wdata, input rdata);
   modport bank (input en, we, addr, wdata, output rdata);
endinterface

`default_nettype wire

// File: hdl/ccm_apb_port.sv
/*
 * APB slave for the CCM: memory/register decode, control and error
 * counter registers, memory request issue and transfer completion
 */
`timescale 1ns/100ps
`default_nettype none

module ccm_apb_port
   import ccm_cfg_pkg::*;
#(
   parameter int NUM_BANKS  = 4,
   parameter int BANK_DEPTH = 256
) (
   input  wire               clk,
   input  wire               rst,
   input  wire               psel,
   input  wire               penable,
   input  wire               pwrite,
   input  wire  [ADDR_W-1:0] paddr,
   input  wire  [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr,
   ccm_req_if.front          req
);

   localparam int MEM_WORDS = NUM_BANKS * BANK_DEPTH;
   localparam int MEM_AW    = $clog2(MEM_WORDS);

   ccm_addr_u        addr_u;
   logic             setup_ph;
   logic             is_csr;
   logic             mem_ok;
   logic             csr_wr;
   logic             rdy_q;
   logic             err_q;
   logic [31:0]      csr_val;
   logic [31:0]      rdata_q;
   logic             ecc_dis_q;
   logic [31:0]      inject_q;
   logic [CNT_W-1:0] sec_cnt_q;
   logic [CNT_W-1:0] ded_cnt_q;

   // ******************************
   // Address decode
   // ******************************
   assign addr_u   = paddr;
   assign setup_ph = psel && !penable;
   assign is_csr   = addr_u.csr.region;
   assign mem_ok   = !addr_u.mem.region && (int'(addr_u.mem.word_offset) < MEM_WORDS);

   // Registers complete in the first access cycle, written at its end
   assign csr_wr = psel && penable && rdy_q && is_csr && pwrite;

   always_comb begin
      case (addr_u.csr.reg_sel)
         REG_CTRL:    csr_val = {31'b0, ecc_dis_q};
         REG_INJECT:  csr_val = inject_q;
         REG_SEC_CNT: csr_val = 32'(sec_cnt_q);
         default:     csr_val = 32'(ded_cnt_q);
      endcase
   end

   // Request fields follow the APB bus, stable through the transfer
   assign req.we          = pwrite;
   assign req.word_offset = addr_u.mem.word_offset[MEM_AW-1:0];
   assign req.wdata       = pwdata;
   assign req.flip_mask   = inject_q;
   assign req.ecc_disable = ecc_dis_q;

   // ******************************
   // Control and counters
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         req.req   <= 1'b0;
         rdy_q     <= 1'b0;
         err_q     <= 1'b0;
         ecc_dis_q <= 1'b0;
         inject_q  <= '0;
         sec_cnt_q <= '0;
         ded_cnt_q <= '0;
      end else begin
         req.req <= setup_ph && mem_ok;                    // High in first access cycle
         rdy_q   <= (setup_ph && (is_csr || !mem_ok))      // Zero wait states
                    || (req.req && req.we);                // Write, one wait state
         err_q   <= setup_ph && !is_csr && !mem_ok;

         if (req.req && req.we) inject_q <= '0;           // One shot

         if (req.rvalid && req.sec && sec_cnt_q != '1) sec_cnt_q <= sec_cnt_q + 1'b1;
         if (req.rvalid && req.ded && ded_cnt_q != '1) ded_cnt_q <= ded_cnt_q + 1'b1;

         if (csr_wr) begin
            case (addr_u.csr.reg_sel)
               REG_CTRL:    ecc_dis_q <= pwdata[0];
               REG_INJECT:  inject_q  <= pwdata;
               REG_SEC_CNT: sec_cnt_q <= '0;          // Any value clears
               default:     ded_cnt_q <= '0;
            endcase
         end
      end
   end

   // Register read data captured in setup
   always_ff @(posedge clk) begin
      if (setup_ph) rdata_q <= is_csr ? csr_val : '0;
   end

   // Memory reads finish on rvalid
   assign pready  = rdy_q || req.rvalid;
   assign pslverr = err_q || (req.rvalid && req.ded);
   assign prdata  = req.rvalid ? req.rdata : rdata_q;

   // APB protocol from the host side
   a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

`default_nettype wire

// File: hdl/ccm_bank_ctrl.sv
/*
 * Bank controller: steers requests to one SRAM bank, encodes and injects
 * errors on write, decodes and corrects on read
 */
`timescale 1ns/100ps
`default_nettype none

module ccm_bank_ctrl
   import ccm_ecc_pkg::*;
#(
   parameter int NUM_BANKS  = 4,
   parameter int BANK_DEPTH = 256
) (
   input  wire      clk,
   input  wire      rst,
   ccm_req_if.ctrl  req,
   ccm_sram_if.ctrl sram
);

   localparam int BANK_BITS = $clog2(NUM_BANKS);
   localparam int ROW_AW    = $clog2(BANK_DEPTH);

   logic [BANK_BITS-1:0] bank_sel;
   logic [BANK_BITS-1:0] bank_q;
   logic [ROW_AW-1:0]    row;
   logic                 rd_pend;
   ccm_code_t            wr_code;
   ccm_code_t            rd_code;
   ecc_result_t          dec;

   // ******************************
   // Request steering
   // ******************************
   assign bank_sel = req.word_offset[BANK_BITS-1:0];        // Offset modulo banks
   assign row      = req.word_offset[BANK_BITS +: ROW_AW];  // Offset divided by banks

   // Flip mask lands on the stored data bits after encoding
   always_comb begin
      wr_code      = ecc_encode(req.wdata);
      wr_code.data = wr_code.data ^ req.flip_mask;
   end

   always_comb begin
      for (int i = 0; i < NUM_BANKS; i++) begin
         sram.en[i]    = req.req && (bank_sel == BANK_BITS'(i));
         sram.we[i]    = req.req && req.we && (bank_sel == BANK_BITS'(i));
         sram.addr[i]  = row;
         sram.wdata[i] = wr_code;
      end
   end

   // ******************************
   // Read return
   // ******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= req.req && !req.we;
      end
   end

   always_ff @(posedge clk) begin
      if (req.req) bank_q <= bank_sel;   // Which bank answers next cycle
   end

   assign rd_code = sram.rdata[bank_q];
   assign dec     = ecc_decode(rd_code);

   assign req.rvalid = rd_pend;
   assign req.rdata  = req.ecc_disable ? rd_code.data : dec.data;   // Raw bits when off
   assign req.sec    = rd_pend && !req.ecc_disable && dec.sec;
   assign req.ded    = rd_pend && !req.ecc_disable && dec.ded;

   // Front end must hold off until the read returns
   a_no_req_pending: assert property (@(posedge clk) disable iff (rst)
      rd_pend |-> !req.req);

   a_one_bank: assert property (@(posedge clk) disable iff (rst) $onehot0(sram.en));

endmodule

`default_nettype wire

// File: hdl/ccm_sram_bank.sv
/*
 * Behavioral SRAM bank of code words, synchronous write, registered read
 */
`timescale 1ns/100ps
`default_nettype none

module ccm_sram_bank
   import ccm_ecc_pkg::*;
#(
   parameter int BANK_DEPTH = 256,
   parameter int BANK_ID    = 0
) (
   input wire       clk,
   ccm_sram_if.bank sram
);

   ccm_code_t mem [BANK_DEPTH];
   ccm_code_t rdata_q;

   // ******************************
   // Array access
   // ******************************
   always_ff @(posedge clk) begin
      if (sram.en[BANK_ID]) begin
         if (sram.we[BANK_ID]) begin
            mem[sram.addr[BANK_ID]] <= sram.wdata[BANK_ID];
         end else begin
            rdata_q <= mem[sram.addr[BANK_ID]];   // Valid next cycle
         end
      end
   end

   assign sram.rdata[BANK_ID] = rdata_q;

   // Controller row must fit this bank
   a_addr_range: assert property (@(posedge clk)
      sram.en[BANK_ID] |-> (int'(sram.addr[BANK_ID]) < BANK_DEPTH));

endmodule

`default_nettype wire

// File: hdl/ccm_top.sv
/*
 * CCM top level: APB front end, bank controller with SECDED and a row of
 * interleaved SRAM banks
 */
`timescale 1ns/100ps
`default_nettype none

module ccm_top
   import ccm_cfg_pkg::*;
#(
   parameter int NUM_BANKS  = DEF_NUM_BANKS,    // Power of two, 2 to 8
   parameter int BANK_DEPTH = DEF_BANK_DEPTH
) (
   input  wire               clk,
   input  wire               rst,
   input  wire               psel,
   input  wire               penable,
   input  wire               pwrite,
   input  wire  [ADDR_W-1:0] paddr,
   input  wire  [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr
);

   localparam int MEM_AW = $clog2(NUM_BANKS * BANK_DEPTH);
   localparam int ROW_AW = $clog2(BANK_DEPTH);

   ccm_req_if  #(.BANK_AW(MEM_AW)) req_if ();
   ccm_sram_if #(.NUM_BANKS(NUM_BANKS), .BANK_AW(ROW_AW)) sram_if ();

   // ******************************
   // Front end and controller
   // ******************************
   ccm_apb_port #(
      .NUM_BANKS (NUM_BANKS),
      .BANK_DEPTH(BANK_DEPTH)
   ) u_apb (
      .clk    (clk),
      .rst    (rst),
      .psel   (psel),
      .penable(penable),
      .pwrite (pwrite),
      .paddr  (paddr),
      .pwdata (pwdata),
      .prdata (prdata),
      .pready (pready),
      .pslverr(pslverr),
      .req    (req_if.front)
   );

   ccm_bank_ctrl #(
      .NUM_BANKS (NUM_BANKS),
      .BANK_DEPTH(BANK_DEPTH)
   ) u_ctrl (
      .clk (clk),
      .rst (rst),
      .req (req_if.ctrl),
      .sram(sram_if.ctrl)
   );

   // One bank per interleave slot
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      ccm_sram_bank #(
         .BANK_DEPTH(BANK_DEPTH),
         .BANK_ID   (b)
      ) u_bank (
         .clk (clk),
         .sram(sram_if.bank)
      );
   end

endmodule

`default_nettype wire

// File: dv/ccm_tb_tests.svh
/*
 * Directed CCM tests of register reset values, readback, ECC and range errors
 */

task automatic reset_value_reads();
   reg_read_check(REG_CTRL, 32'h0);
   reg_read_check(REG_INJECT, 32'h0);
   reg_read_check(REG_SEC_CNT, 32'h0);
   reg_read_check(REG_DED_CNT, 32'h0);
   end_test("reset_values");
endtask

// First two rows and the last row cover every bank
task automatic write_read_back();
   int          offs [$];
   logic [31:0] w;
   for (int i = 0; i < 2 * NUM_BANKS; i++) offs.push_back(i);
   for (int i = MEM_WORDS - NUM_BANKS; i < MEM_WORDS; i++) offs.push_back(i);
   foreach (offs[i]) begin
      w              = $random(seed);
      ref_mem[offs[i]] = w;
      mem_write(offs[i], w);
   end
   foreach (offs[i]) mem_read_check(offs[i], ref_mem[offs[i]], 1'b0);
   end_test("readback");
endtask

task automatic single_bit_correction();
   logic [31:0] w;
   logic [31:0] mask;
   w            = $random(seed);
   mask         = 32'h1 << ($unsigned($random(seed)) % 32);
   ref_mem[100] = w;
   reg_write(REG_INJECT, mask);
   reg_read_check(REG_INJECT, mask);
   mem_write(100, w);
   reg_read_check(REG_INJECT, 32'h0);       // Cleared by the write
   mem_read_check(100, w, 1'b0);            // Corrected
   reg_read_check(REG_SEC_CNT, 32'h1);
   reg_read_check(REG_DED_CNT, 32'h0);
   end_test("single_error");
endtask

task automatic double_bit_detection();
   logic [31:0] w;
   int          b0;
   int          b1;
   w  = $random(seed);
   b0 = $unsigned($random(seed)) % 32;
   b1 = (b0 + 1 + ($unsigned($random(seed)) % 31)) % 32;   // Never equal to b0
   reg_write(REG_INJECT, (32'h1 << b0) | (32'h1 << b1));
   mem_write(101, w);
   mem_read_check(101, w, 1'b1);
   reg_read_check(REG_DED_CNT, 32'h1);
   reg_read_check(REG_SEC_CNT, 32'h1);
   reg_write(REG_SEC_CNT, $random(seed));
   reg_read_check(REG_SEC_CNT, 32'h0);
   reg_write(REG_DED_CNT, $random(seed));
   reg_read_check(REG_DED_CNT, 32'h0);
   end_test("double_error");
endtask

task automatic ecc_bypass();
   logic [31:0] w;
   logic [31:0] mask;
   w            = $random(seed);
   mask         = 32'h1 << ($unsigned($random(seed)) % 32);
   ref_mem[102] = w;
   reg_write(REG_CTRL, 32'h1);
   reg_read_check(REG_CTRL, 32'h1);
   reg_write(REG_INJECT, mask);
   mem_write(102, w);
   mem_read_check(102, w ^ mask, 1'b0);     // Raw stored bits
   reg_read_check(REG_SEC_CNT, 32'h0);
   reg_read_check(REG_DED_CNT, 32'h0);
   reg_write(REG_CTRL, 32'h0);
   mem_read_check(102, w, 1'b0);
   reg_read_check(REG_SEC_CNT, 32'h1);
   end_test("ecc_disable");
endtask

task automatic out_of_range_access();
   logic [31:0] rd;
   logic        err;
   int          waits;
   apb_xfer(1'b1, mem_addr(MEM_WORDS), $random(seed), rd, err, waits);
   check_val("pslverr", 32'(err), 32'h1);
   check_val("wait_states", waits, 0);
   apb_xfer(1'b0, mem_addr(MEM_WORDS), 32'h0, rd, err, waits);
   check_val("pslverr", 32'(err), 32'h1);
   check_val("wait_states", waits, 0);
   mem_read_check(0, ref_mem[0], 1'b0);     // Wrapped offset untouched
   end_test("out_of_range");
endtask

// File: dv/ccm_tb.sv
/*
 * CCM testbench with an APB host model, a reference memory and directed tests
 */
`timescale 1ns/100ps
`default_nettype none

module ccm_tb
   import ccm_cfg_pkg::*;
();

   localparam int NUM_BANKS  = DEF_NUM_BANKS;
   localparam int BANK_DEPTH = DEF_BANK_DEPTH;
   localparam int MEM_WORDS  = NUM_BANKS * BANK_DEPTH;
   localparam int TIMEOUT    = 20;     // Cycles allowed for pready

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [15:0] paddr;
   logic [31:0] pwdata;
   wire  [31:0] prdata;
   wire         pready;
   wire         pslverr;

   logic [31:0] ref_mem [MEM_WORDS];   // Expected memory words
   int          seed = 10;
   int          errors;
   int          checks;
   int          test_errs;
   event        xfer_timeout;

   ccm_top #(
      .NUM_BANKS (NUM_BANKS),
      .BANK_DEPTH(BANK_DEPTH)
   ) uut (
      .clk    (clk),
      .rst    (rst),
      .psel   (psel),
      .penable(penable),
      .pwrite (pwrite),
      .paddr  (paddr),
      .pwdata (pwdata),
      .prdata (prdata),
      .pready (pready),
      .pslverr(pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ******************************
   // Address layout and checking
   // ******************************
   function automatic logic [15:0] mem_addr(input int offset);
      return {1'b0, 13'(offset), 2'b00};       // Region bit clear
   endfunction

   function automatic logic [15:0] reg_addr(input logic [1:0] sel);
      return {1'b1, 11'b0, sel, 2'b00};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
         errors++;
         test_errs++;
      end
   endtask

   task automatic end_test(input string name);
      $display("%-14s done, %0d mismatches", name, test_errs);
      test_errs = 0;
   endtask

   // ******************************
   // APB host
   // ******************************
   task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output logic err, output int waits);
      @(negedge clk);
      psel    = 1'b1;                          // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdat;
      @(negedge clk);
      penable = 1'b1;
      waits   = 0;
      #1;
      while (!pready && waits < TIMEOUT) begin
         @(negedge clk);
         #1;
         waits++;                              // One more wait state
      end
      if (!pready) begin
         $display("Timeout: no pready within %0d cycles at address 0x%04h", TIMEOUT, addr);
         errors++;
         -> xfer_timeout;
      end
      rdat = prdata;
      err  = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic mem_write(input int offset, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      int          waits;
      apb_xfer(1'b1, mem_addr(offset), data, rd, err, waits);
      check_val("pslverr", 32'(err), 32'h0);
      check_val("wait_states", waits, 1);
   endtask

   // Data is not compared when an uncorrectable error is expected
   task automatic mem_read_check(input int offset, input logic [31:0] exp_data,
                                 input logic exp_err);
      logic [31:0] rd;
      logic        err;
      int          waits;
      apb_xfer(1'b0, mem_addr(offset), 32'h0, rd, err, waits);
      if (!exp_err) check_val("prdata", rd, exp_data);
      check_val("pslverr", 32'(err), 32'(exp_err));
      check_val("wait_states", waits, 1);
   endtask

   task automatic reg_write(input logic [1:0] sel, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      int          waits;
      apb_xfer(1'b1, reg_addr(sel), data, rd, err, waits);
      check_val("pslverr", 32'(err), 32'h0);
      check_val("wait_states", waits, 0);
   endtask

   task automatic reg_read_check(input logic [1:0] sel, input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      int          waits;
      apb_xfer(1'b0, reg_addr(sel), 32'h0, rd, err, waits);
      check_val("prdata", rd, exp);
      check_val("pslverr", 32'(err), 32'h0);
      check_val("wait_states", waits, 0);
   endtask

   `include "ccm_tb_tests.svh"

   // Stuck transfer ends the run
   initial begin
      @(xfer_timeout);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      rst       = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      errors    = 0;
      checks    = 0;
      test_errs = 0;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      reset_value_reads();
      write_read_back();
      single_bit_correction();
      double_bit_detection();
      ecc_bypass();
      out_of_range_access();

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+dv
hdl/ccm_cfg_pkg.sv
hdl/ccm_ecc_pkg.sv
hdl/ccm_if.sv
hdl/ccm_apb_port.sv
hdl/ccm_bank_ctrl.sv
hdl/ccm_sram_bank.sv
hdl/ccm_top.sv
dv/ccm_tb.sv

// File: Makefile
# Verilator flow for the CCM: lint, simulate, clean

TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP       = ccm_tb
RTL_TOP   = ccm_top
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell sed -n 's/^\([^+].*\.s\?v\)$$/\1/p' $(FILELIST)) dv/ccm_tb_tests.svh
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
